// ==== src/cpuPkg.sv ====
/*
   shared widths, instruction field positions and encodings
   for the 16-bit integer pipeline slice
*/
package cpuPkg;

   // datapath and register index widths
   localparam int dataW    = 16;
   localparam int regAddrW = 3;
   localparam int numRegs  = 2 ** regAddrW;

   // data memory geometry, address is the low bits of the effective address
   localparam int memAddrW = 8;
   localparam int memWords = 256;

   // instruction field positions
   localparam int opMsb = 15;
   localparam int opLsb = 12;
   localparam int rdMsb = 11;
   localparam int rdLsb = 9;
   localparam int rsMsb = 8;
   localparam int rsLsb = 6;
   localparam int rtMsb = 5;
   localparam int rtLsb = 3;

   // immediate widths, all taken from bit 0 upward
   localparam int imm6W = 6;
   localparam int imm8W = 8;
   localparam int imm9W = 9;

   // jal writes its link value here
   localparam logic [regAddrW-1:0] linkReg = 3'd7;

   typedef enum logic [3:0] {
      opAdd  = 4'h0,
      opSub  = 4'h1,
      opAnd  = 4'h2,
      opXor  = 4'h3,
      opAddi = 4'h4,
      opLdi  = 4'h5,
      opLd   = 4'h6,
      opSt   = 4'h7,
      opBeqz = 4'h8,
      opBltz = 4'h9,
      opJal  = 4'hA,
      opJr   = 4'hB,
      opNop  = 4'hF
   } opcode_e;

   typedef enum logic [1:0] {aluAdd, aluSub, aluAnd, aluXor} aluOp_e;

   // operand source picked by the forwarding unit
   typedef enum logic [1:0] {fwdNone, fwdXm, fwdMw} fwdSel_e;

endpackage

// ==== src/stageIf.sv ====
/*
   stage bundle, one instruction's control and data between two pipeline stages
*/
`timescale 1ns/1ps
interface stageIf import cpuPkg::*; ();
   logic                valid;
   opcode_e             opcode;
   logic [dataW-1:0]    pc;
   logic [regAddrW-1:0] destReg;
   logic                writesReg;
   // operand values with their indices and read flags
   logic [dataW-1:0]    srcA;
   logic [dataW-1:0]    srcB;
   logic [regAddrW-1:0] srcAIdx;
   logic [regAddrW-1:0] srcBIdx;
   logic                readsA;
   logic                readsB;
   logic [dataW-1:0]    imm;
   aluOp_e              aluOp;
   logic [dataW-1:0]    result;
   logic [dataW-1:0]    storeData;

   modport drv (output valid, opcode, pc, destReg, writesReg, srcA, srcB, srcAIdx, srcBIdx,
                readsA, readsB, imm, aluOp, result, storeData);
   modport rcv (input valid, opcode, pc, destReg, writesReg, srcA, srcB, srcAIdx, srcBIdx,
                readsA, readsB, imm, aluOp, result, storeData);
endinterface

// ==== src/regFile.sv ====
/*
   8 x 16 register file, two read ports and one write port
   a read of the register being written returns the new value
*/
`timescale 1ns/1ps
module regFile import cpuPkg::*; (
   input  logic                clk,
   input  logic                arstN,
   input  logic [regAddrW-1:0] raddrA,
   input  logic [regAddrW-1:0] raddrB,
   input  logic                we,
   input  logic [regAddrW-1:0] waddr,
   input  logic [dataW-1:0]    wdata,
   output logic [dataW-1:0]    rdataA,
   output logic [dataW-1:0]    rdataB
);
   logic [dataW-1:0] regs [numRegs];

   // all registers start at zero, r0 included
   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         regs <= '{default: '0};
      end else if (we) begin
         regs[waddr] <= wdata;
      end
   end

   // write-to-read bypass covers the distance-3 consumer
   assign rdataA = (we && (waddr == raddrA)) ? wdata : regs[raddrA];
   assign rdataB = (we && (waddr == raddrB)) ? wdata : regs[raddrB];

endmodule

// ==== src/alu.sv ====
/*
   16-bit ALU, add, subtract, and, xor, with zero and sign flags
*/
`timescale 1ns/1ps
module alu import cpuPkg::*; (
   input  logic [dataW-1:0] a,
   input  logic [dataW-1:0] b,
   input  aluOp_e           op,
   output logic [dataW-1:0] y,
   output logic             zero,
   output logic             sign
);

   // add and sub wrap around, no carry out
   always_comb begin
      case (op)
         aluAdd: y = a + b;
         aluSub: y = a - b;
         aluAnd: y = a & b;
         aluXor: y = a ^ b;
         default: y = a + b;
      endcase
   end

   assign zero = (y == '0);
   // msb as two's complement sign
   assign sign = y[dataW-1];

endmodule

// ==== src/decodeStage.sv ====
/*
   decode stage, splits the instruction, extends immediates,
   reads operands and registers the decode/execute bundle
*/
`timescale 1ns/1ps
module decodeStage import cpuPkg::*; (
   input  logic                clk,
   input  logic                arstN,
   input  logic                instrValid,
   input  logic [dataW-1:0]    instr,
   input  logic [dataW-1:0]    pc,
   input  logic [dataW-1:0]    rdataA,
   input  logic [dataW-1:0]    rdataB,
   output logic [regAddrW-1:0] raddrA,
   output logic [regAddrW-1:0] raddrB,
   stageIf.drv                 dx
);
   opcode_e             op;
   logic [regAddrW-1:0] rd;
   logic [regAddrW-1:0] rs;
   logic [regAddrW-1:0] rt;
   logic                regOp;
   logic                rdOnB;
   logic                readsA;
   logic                readsB;
   logic                writesReg;
   logic [dataW-1:0]    imm;
   aluOp_e              aluOp;

   assign op = opcode_e'(instr[opMsb:opLsb]);
   assign rd = instr[rdMsb:rdLsb];
   assign rs = instr[rsMsb:rsLsb];
   assign rt = instr[rtMsb:rtLsb];

   // three-register ALU ops
   assign regOp     = op inside {opAdd, opSub, opAnd, opXor};
   // stores and branches read rd on port B
   assign rdOnB     = op inside {opSt, opBeqz, opBltz};
   assign readsA    = regOp || (op inside {opAddi, opLd, opSt, opJr});
   assign readsB    = regOp || rdOnB;
   assign writesReg = regOp || (op inside {opAddi, opLdi, opLd, opJal});

   assign raddrA = rs;
   assign raddrB = rdOnB ? rd : rt;

   // immediate select and sign extension
   always_comb begin
      case (op)
         opAddi, opLd, opSt: imm = {{(dataW-imm6W){instr[imm6W-1]}}, instr[imm6W-1:0]};
         opLdi, opBeqz, opBltz: imm = {{(dataW-imm8W){instr[imm8W-1]}}, instr[imm8W-1:0]};
         opJal: imm = {{(dataW-imm9W){instr[imm9W-1]}}, instr[imm9W-1:0]};
         default: imm = '0;
      endcase
   end

   // address and link adds go through aluAdd
   always_comb begin
      case (op)
         opSub: aluOp = aluSub;
         opAnd: aluOp = aluAnd;
         opXor: aluOp = aluXor;
         default: aluOp = aluAdd;
      endcase
   end

   // control part of the bundle
   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         dx.valid     <= 1'b0;
         dx.opcode    <= opNop;
         dx.writesReg <= 1'b0;
         dx.readsA    <= 1'b0;
         dx.readsB    <= 1'b0;
      end else begin
         dx.valid     <= instrValid;
         dx.opcode    <= op;
         dx.writesReg <= writesReg;
         dx.readsA    <= readsA;
         dx.readsB    <= readsB;
      end
   end

   // payload part
   always_ff @(posedge clk) begin
      dx.pc      <= pc;
      dx.destReg <= (op == opJal) ? linkReg : rd;
      dx.srcA    <= rdataA;
      dx.srcB    <= rdataB;
      dx.srcAIdx <= raddrA;
      dx.srcBIdx <= raddrB;
      dx.imm     <= imm;
      dx.aluOp   <= aluOp;
   end

   // results are produced in execute
   assign dx.result    = '0;
   assign dx.storeData = '0;

endmodule

// ==== src/forwardUnit.sv ====
/*
   forwarding unit, picks the youngest in-flight producer
   for each execute-stage source register
*/
`timescale 1ns/1ps
module forwardUnit import cpuPkg::*; (
   stageIf.rcv                 dx,
   stageIf.rcv                 xm,
   input  logic                mwValid,
   input  logic [regAddrW-1:0] mwReg,
   input  logic                mwWrites,
   output fwdSel_e             fwdA,
   output fwdSel_e             fwdB
);
   logic xmHitA;
   logic xmHitB;
   logic mwHitA;
   logic mwHitB;
   logic loadUse;

   // distance 1, result still in the execute/memory register
   assign xmHitA = xm.valid && xm.writesReg && (xm.destReg == dx.srcAIdx);
   assign xmHitB = xm.valid && xm.writesReg && (xm.destReg == dx.srcBIdx);
   // distance 2, value sits in the memory/write-back register
   assign mwHitA = mwValid && mwWrites && (mwReg == dx.srcAIdx);
   assign mwHitB = mwValid && mwWrites && (mwReg == dx.srcBIdx);

   // youngest producer first
   always_comb begin
      fwdA = fwdNone;
      if (dx.readsA && xmHitA) fwdA = fwdXm;
      else if (dx.readsA && mwHitA) fwdA = fwdMw;
   end

   always_comb begin
      fwdB = fwdNone;
      if (dx.readsB && xmHitB) fwdB = fwdXm;
      else if (dx.readsB && mwHitB) fwdB = fwdMw;
   end

   // a load result is not ready one slot later, the stream has to leave a gap
   assign loadUse = (xm.opcode == opLd) && ((dx.readsA && xmHitA) || (dx.readsB && xmHitB));

   always_comb begin
      assert final (dx.valid !== 1'b1 || !loadUse)
         else $error("load-use hazard, consumer directly behind load to r%0d", xm.destReg);
   end

endmodule

// ==== src/executeStage.sv ====
/*
   execute stage, operand forwarding, ALU, branch and jump resolution,
   link value, redirect and the execute/memory register
*/
`timescale 1ns/1ps
module executeStage import cpuPkg::*; (
   input  logic             clk,
   input  logic             arstN,
   input  fwdSel_e          fwdA,
   input  fwdSel_e          fwdB,
   input  logic [dataW-1:0] mwData,
   stageIf.rcv              dx,
   stageIf.drv              xm,
   output logic             redirectValid,
   output logic [dataW-1:0] redirectPc
);
   logic [dataW-1:0] opA;
   logic [dataW-1:0] opB;
   logic [dataW-1:0] aluA;
   logic [dataW-1:0] aluB;
   logic [dataW-1:0] aluY;
   logic             aluZero;
   logic             aluSign;
   logic             useImm;
   logic             isBranch;
   logic             taken;
   logic             redirect;
   logic [dataW-1:0] pcPlus1;
   logic [dataW-1:0] target;
   logic [dataW-1:0] result;

   function automatic logic [dataW-1:0] fwdMux(input fwdSel_e sel,
                                                input logic [dataW-1:0] fromRf,
                                                input logic [dataW-1:0] fromXm,
                                                input logic [dataW-1:0] fromMw);
      case (sel)
         fwdXm: return fromXm;
         fwdMw: return fromMw;
         default: return fromRf;
      endcase
   endfunction

   assign opA = fwdMux(fwdA, dx.srcA, xm.result, mwData);
   assign opB = fwdMux(fwdB, dx.srcB, xm.result, mwData);

   assign useImm   = dx.opcode inside {opAddi, opLd, opSt};
   assign isBranch = dx.opcode inside {opBeqz, opBltz};

   // branches pass rd through the adder so the flags describe it
   assign aluA = isBranch ? '0 : opA;
   assign aluB = useImm ? dx.imm : opB;

   alu u_alu (
      .a    (aluA),
      .b    (aluB),
      .op   (dx.aluOp),
      .y    (aluY),
      .zero (aluZero),
      .sign (aluSign)
   );

   assign taken = ((dx.opcode == opBeqz) && aluZero) || ((dx.opcode == opBltz) && aluSign);

   // pc-relative target, jr jumps to the forwarded register
   assign pcPlus1 = dx.pc + 1'b1;
   assign target  = (dx.opcode == opJr) ? opA : pcPlus1 + dx.imm;
   assign redirect = dx.valid && (taken || (dx.opcode inside {opJal, opJr}));

   always_comb begin
      case (dx.opcode)
         opLdi: result = dx.imm;
         opJal: result = pcPlus1;
         default: result = aluY;
      endcase
   end

   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         xm.valid      <= 1'b0;
         xm.opcode     <= opNop;
         xm.writesReg  <= 1'b0;
         xm.readsA     <= 1'b0;
         xm.readsB     <= 1'b0;
         redirectValid <= 1'b0;
      end else begin
         xm.valid      <= dx.valid;
         xm.opcode     <= dx.opcode;
         xm.writesReg  <= dx.writesReg;
         xm.readsA     <= dx.readsA;
         xm.readsB     <= dx.readsB;
         redirectValid <= redirect;
      end
   end

   // forwarded operands travel on, store data is forwarded B
   always_ff @(posedge clk) begin
      xm.pc        <= dx.pc;
      xm.destReg   <= dx.destReg;
      xm.srcA      <= opA;
      xm.srcB      <= opB;
      xm.srcAIdx   <= dx.srcAIdx;
      xm.srcBIdx   <= dx.srcBIdx;
      xm.imm       <= dx.imm;
      xm.aluOp     <= dx.aluOp;
      xm.result    <= result;
      xm.storeData <= opB;
      redirectPc   <= target;
   end

   // a redirect belongs to the instruction now in memory stage and carries a known target
   assert property (@(posedge clk) disable iff (!arstN)
                    redirectValid |-> xm.valid && !$isunknown(redirectPc))
      else $error("redirect with no valid instruction in memory stage or an unknown target");

endmodule

// ==== src/memStage.sv ====
/*
   memory stage, 256-word data memory, load or ALU result select
   and the memory/write-back register feeding write-back
*/
`timescale 1ns/1ps
module memStage import cpuPkg::*; (
   input  logic                clk,
   input  logic                arstN,
   stageIf.rcv                 xm,
   output logic                mwValid,
   output logic [regAddrW-1:0] mwReg,
   output logic [dataW-1:0]    mwData,
   output logic                mwWrites,
   output logic                wbValid,
   output logic [regAddrW-1:0] wbReg,
   output logic [dataW-1:0]    wbData
);
   logic [dataW-1:0]    mem [memWords];
   logic [memAddrW-1:0] addr;
   logic [dataW-1:0]    loadWord;

   // word address from the low bits of rs + imm6
   assign addr     = xm.result[memAddrW-1:0];
   assign loadWord = mem[addr];

   always_ff @(posedge clk) begin
      if (xm.valid && (xm.opcode == opSt)) begin
         mem[addr] <= xm.storeData;
      end
   end

   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         mwValid  <= 1'b0;
         mwWrites <= 1'b0;
      end else begin
         mwValid  <= xm.valid;
         mwWrites <= xm.writesReg;
      end
   end

   always_ff @(posedge clk) begin
      mwReg  <= xm.destReg;
      mwData <= (xm.opcode == opLd) ? loadWord : xm.result;
   end

   // only register writers retire on the write-back port
   assign wbValid = mwValid && mwWrites;
   assign wbReg   = mwReg;
   assign wbData  = mwData;

   assert property (@(posedge clk) disable iff (!arstN) wbValid |-> !$isunknown(wbData))
      else $error("write-back to r%0d with unknown data", wbReg);

endmodule

// ==== src/pipeCore.sv ====
/*
   pipeline core top, decode, execute and memory/write-back stages
   around the register file and the forwarding unit
*/
`timescale 1ns/1ps
module pipeCore import cpuPkg::*; (
   input  logic                clk,
   input  logic                arstN,
   input  logic                instrValid,
   input  logic [dataW-1:0]    instr,
   input  logic [dataW-1:0]    pc,
   output logic                wbValid,
   output logic [regAddrW-1:0] wbReg,
   output logic [dataW-1:0]    wbData,
   output logic                redirectValid,
   output logic [dataW-1:0]    redirectPc
);
   logic [regAddrW-1:0] raddrA;
   logic [regAddrW-1:0] raddrB;
   logic [dataW-1:0]    rdataA;
   logic [dataW-1:0]    rdataB;
   fwdSel_e             fwdA;
   fwdSel_e             fwdB;
   logic                mwValid;
   logic [regAddrW-1:0] mwReg;
   logic [dataW-1:0]    mwData;
   logic                mwWrites;

   // decode to execute and execute to memory bundles
   stageIf dx ();
   stageIf xm ();

   // write port fed from the memory/write-back register
   regFile u_regFile (
      .clk    (clk),
      .arstN  (arstN),
      .raddrA (raddrA),
      .raddrB (raddrB),
      .we     (wbValid),
      .waddr  (mwReg),
      .wdata  (mwData),
      .rdataA (rdataA),
      .rdataB (rdataB)
   );

   decodeStage u_decode (
      .clk        (clk),
      .arstN      (arstN),
      .instrValid (instrValid),
      .instr      (instr),
      .pc         (pc),
      .rdataA     (rdataA),
      .rdataB     (rdataB),
      .raddrA     (raddrA),
      .raddrB     (raddrB),
      .dx         (dx.drv)
   );

   forwardUnit u_forward (
      .dx       (dx.rcv),
      .xm       (xm.rcv),
      .mwValid  (mwValid),
      .mwReg    (mwReg),
      .mwWrites (mwWrites),
      .fwdA     (fwdA),
      .fwdB     (fwdB)
   );

   executeStage u_execute (
      .clk           (clk),
      .arstN         (arstN),
      .fwdA          (fwdA),
      .fwdB          (fwdB),
      .mwData        (mwData),
      .dx            (dx.rcv),
      .xm            (xm.drv),
      .redirectValid (redirectValid),
      .redirectPc    (redirectPc)
   );

   memStage u_mem (
      .clk      (clk),
      .arstN    (arstN),
      .xm       (xm.rcv),
      .mwValid  (mwValid),
      .mwReg    (mwReg),
      .mwData   (mwData),
      .mwWrites (mwWrites),
      .wbValid  (wbValid),
      .wbReg    (wbReg),
      .wbData   (wbData)
   );

endmodule

// ==== tb/pipeChecker.sv ====
/*
   pipeline checker, in-order architectural model of the core and a monitor
   that compares write-back and redirect strobes against the model
*/
`timescale 1ns/1ps
module pipeChecker import cpuPkg::*; (
   input  logic                clk,
   input  logic                arstN,
   input  logic                instrValid,
   input  logic [dataW-1:0]    instr,
   input  logic [dataW-1:0]    pc,
   input  logic                wbValid,
   input  logic [regAddrW-1:0] wbReg,
   input  logic [dataW-1:0]    wbData,
   input  logic                redirectValid,
   input  logic [dataW-1:0]    redirectPc,
   output int                  passCount,
   output int                  failCount,
   output int                  retired
);
   // architectural state, updated in program order at the strobe
   logic [dataW-1:0]    regs [numRegs];
   // starts unknown, as the data memory does
   logic [dataW-1:0]    mem [memWords];
   // predicted events, each with its due cycle and instruction number
   int                  wbDue [$];
   int                  wbId [$];
   logic [regAddrW-1:0] wbRegQ [$];
   logic [dataW-1:0]    wbDataQ [$];
   int                  rdDue [$];
   int                  rdId [$];
   logic [dataW-1:0]    rdPcQ [$];
   int                  retDue [$];
   int                  retId [$];
   logic [dataW-1:0]    retWord [$];
   logic [dataW-1:0]    retPc [$];
   bit                  bad [0:1023];
   int                  cyc;
   int                  seqNum;

   // sequential execution of one instruction word
   task automatic runModel(input logic [dataW-1:0] word, input logic [dataW-1:0] ipc,
                           output logic writes, output logic [regAddrW-1:0] dst,
                           output logic [dataW-1:0] val, output logic redir,
                           output logic [dataW-1:0] tgt);
      logic [3:0]          op;
      logic [regAddrW-1:0] rd;
      logic [dataW-1:0]    i6;
      logic [dataW-1:0]    i8;
      logic [dataW-1:0]    i9;
      logic [dataW-1:0]    a;
      logic [dataW-1:0]    b;
      logic [dataW-1:0]    d;
      logic [dataW-1:0]    ea;
      logic [dataW-1:0]    next;
      op   = word[15:12];
      rd   = word[11:9];
      a    = regs[word[8:6]];
      b    = regs[word[5:3]];
      d    = regs[rd];
      i6   = {{10{word[5]}}, word[5:0]};
      i8   = {{8{word[7]}}, word[7:0]};
      i9   = {{7{word[8]}}, word[8:0]};
      ea   = a + i6;
      next = ipc + 16'd1;
      writes = op inside {opAdd, opSub, opAnd, opXor, opAddi, opLdi, opLd, opJal};
      case (op)
         opAdd: val = a + b;
         opSub: val = a - b;
         opAnd: val = a & b;
         opXor: val = a ^ b;
         opAddi: val = ea;
         opLdi: val = i8;
         opLd: val = mem[ea[7:0]];
         opJal: val = next;
         default: val = '0;
      endcase
      // jal links into r7
      dst   = (op == opJal) ? 3'd7 : rd;
      redir = ((op == opBeqz) && (d == '0)) || ((op == opBltz) && d[15]) ||
              (op inside {opJal, opJr});
      tgt   = (op == opJr) ? a : next + ((op == opJal) ? i9 : i8);
      if (op == opSt)
         mem[ea[7:0]] = d;
      if (writes)
         regs[dst] = val;
   endtask

   initial begin
      passCount = 0;
      failCount = 0;
      retired   = 0;
      cyc       = 0;
      seqNum    = 0;
      for (int k = 0; k < numRegs; k++)
         regs[k] = '0;
   end

   always @(posedge clk) begin : monitor
      logic                writes;
      logic [regAddrW-1:0] dst;
      logic [dataW-1:0]    val;
      logic                redir;
      logic [dataW-1:0]    tgt;
      logic [dataW-1:0]    word;
      int                  id;
      int                  due;
      if (!arstN) begin
         if (wbValid !== 1'b0 || redirectValid !== 1'b0) begin
            $display("error: output strobe active during reset at %0t", $time);
            failCount++;
         end
      end else begin
         // write-back port, exactly 3 cycles after the strobe
         if (wbDue.size() > 0 && wbDue[0] == cyc) begin
            due = wbDue.pop_front();
            id  = wbId.pop_front();
            dst = wbRegQ.pop_front();
            val = wbDataQ.pop_front();
            if (wbValid !== 1'b1) begin
               $display("error: instr %0d did not write back on time", id);
               bad[id] = 1'b1;
            end else begin
               if (wbReg !== dst) begin
                  $display("CHECK FAILED wbReg: instr %0d expected 0x%h got 0x%h",
                           id, dst, wbReg);
                  bad[id] = 1'b1;
               end
               if (wbData !== val) begin
                  $display("CHECK FAILED wbData: instr %0d expected 0x%h got 0x%h",
                           id, val, wbData);
                  bad[id] = 1'b1;
               end
            end
         end else if (wbValid !== 1'b0) begin
            $display("error: write-back strobe with no instruction due at %0t", $time);
            failCount++;
         end
         // redirect port, exactly 2 cycles after the strobe
         if (rdDue.size() > 0 && rdDue[0] == cyc) begin
            due = rdDue.pop_front();
            id  = rdId.pop_front();
            tgt = rdPcQ.pop_front();
            if (redirectValid !== 1'b1) begin
               $display("error: instr %0d did not redirect on time", id);
               bad[id] = 1'b1;
            end else if (redirectPc !== tgt) begin
               $display("CHECK FAILED redirectPc: instr %0d expected 0x%h got 0x%h",
                        id, tgt, redirectPc);
               bad[id] = 1'b1;
            end
         end else if (redirectValid !== 1'b0) begin
            $display("error: redirect strobe with no branch or jump due at %0t", $time);
            failCount++;
         end
         // retire after the last event an instruction can have
         if (retDue.size() > 0 && retDue[0] == cyc) begin
            due  = retDue.pop_front();
            id   = retId.pop_front();
            word = retWord.pop_front();
            tgt  = retPc.pop_front();
            if (bad[id]) begin
               failCount++;
               $display("instr %0d pc 0x%h word 0x%h FAILED", id, tgt, word);
            end else begin
               passCount++;
               $display("instr %0d pc 0x%h word 0x%h ok", id, tgt, word);
            end
            retired++;
         end
         // new instruction, predict its events
         if (instrValid === 1'b1) begin
            runModel(instr, pc, writes, dst, val, redir, tgt);
            if (writes) begin
               wbDue.push_back(cyc + 3);
               wbId.push_back(seqNum);
               wbRegQ.push_back(dst);
               wbDataQ.push_back(val);
            end
            if (redir) begin
               rdDue.push_back(cyc + 2);
               rdId.push_back(seqNum);
               rdPcQ.push_back(tgt);
            end
            retDue.push_back(cyc + 3);
            retId.push_back(seqNum);
            retWord.push_back(instr);
            retPc.push_back(pc);
            seqNum++;
         end
      end
      cyc++;
   end

endmodule

// ==== tb/tbPipeCore.sv ====
/*
   testbench for the pipeline core, applies an instruction table with gaps
   and reports the verdict from the checker's counts
*/
`timescale 1ns/1ps
module tbPipeCore import cpuPkg::*; ();
   localparam int maxRows   = 64;
   localparam int clkPeriod = 4;

   logic                clk;
   logic                arstN;
   logic                instrValid;
   logic [dataW-1:0]    instr;
   logic [dataW-1:0]    pc;
   logic                wbValid;
   logic [regAddrW-1:0] wbReg;
   logic [dataW-1:0]    wbData;
   logic                redirectValid;
   logic [dataW-1:0]    redirectPc;
   int                  passCount;
   int                  failCount;
   int                  retired;

   // stimulus table, word, pc, idle cycles after, random imm8, expected redirect
   logic [dataW-1:0]    tabInstr [maxRows];
   logic [dataW-1:0]    tabPc [maxRows];
   int                  tabGap [maxRows];
   bit                  tabRand [maxRows];
   bit                  tabTaken [maxRows];
   int                  nRows;
   int                  gapSum;
   int                  expRedirs;
   int                  redirSeen;
   int                  topErrors;
   logic [31:0]         lfsr;

   // fibonacci lfsr, taps 32 22 2 1
   function automatic logic [31:0] lfsrNext(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   // one lfsr step per bit taken
   task automatic takeRandBits(input int n, output logic [dataW-1:0] v);
      v = '0;
      for (int k = 0; k < n; k++) begin
         lfsr = lfsrNext(lfsr);
         v    = {v[dataW-2:0], lfsr[0]};
      end
   endtask

   function automatic logic [dataW-1:0] regOpWord(opcode_e op, int rd, int rs, int rt);
      return {op, rd[2:0], rs[2:0], rt[2:0], 3'b000};
   endfunction

   function automatic logic [dataW-1:0] imm6Word(opcode_e op, int rd, int rs, int imm);
      return {op, rd[2:0], rs[2:0], imm[5:0]};
   endfunction

   function automatic logic [dataW-1:0] imm8Word(opcode_e op, int rd, int imm);
      return {op, rd[2:0], 1'b0, imm[7:0]};
   endfunction

   function automatic logic [dataW-1:0] jalWord(int imm);
      return {opJal, 3'b000, imm[8:0]};
   endfunction

   task automatic addRow(input logic [dataW-1:0] word, input int gap, input bit rnd,
                         input bit tk);
      tabInstr[nRows] = word;
      tabPc[nRows]    = 16'h0100 + nRows[15:0];
      tabGap[nRows]   = gap;
      tabRand[nRows]  = rnd;
      tabTaken[nRows] = tk;
      gapSum          += gap;
      expRedirs       += tk;
      nRows++;
   endtask

   task automatic buildTable();
      // r2 and r3 still zero from reset
      addRow(regOpWord(opAdd, 1, 2, 3), 2, 0, 0);
      addRow(imm8Word(opLdi, 2, 0), 2, 1, 0);
      addRow(imm8Word(opLdi, 3, 'h35), 2, 0, 0);
      addRow(regOpWord(opAdd, 4, 2, 3), 2, 0, 0);
      addRow(regOpWord(opSub, 5, 2, 3), 2, 0, 0);
      addRow(regOpWord(opAnd, 6, 4, 5), 2, 0, 0);
      addRow(regOpWord(opXor, 1, 4, 3), 2, 0, 0);
      addRow(imm6Word(opAddi, 6, 6, -3), 3, 0, 0);
      // back to back, operands at distance 1, 2 and 3
      addRow(imm8Word(opLdi, 1, 'h12), 0, 0, 0);
      addRow(imm6Word(opAddi, 2, 1, 5), 0, 0, 0);
      addRow(regOpWord(opAdd, 3, 1, 2), 0, 0, 0);
      addRow(regOpWord(opSub, 4, 1, 3), 0, 0, 0);
      addRow(regOpWord(opXor, 5, 2, 3), 0, 0, 0);
      addRow(regOpWord(opAnd, 6, 5, 4), 0, 0, 0);
      // r6 pending in both younger stages
      addRow(imm6Word(opAddi, 6, 6, 1), 0, 0, 0);
      addRow(imm6Word(opAddi, 6, 6, 1), 3, 0, 0);
      // store of a fresh value, load back, consumer two slots after the load
      addRow(imm8Word(opLdi, 2, 0), 0, 1, 0);
      addRow(imm6Word(opSt, 2, 0, 4), 0, 0, 0);
      addRow(imm6Word(opLd, 3, 0, 4), 0, 0, 0);
      addRow(imm8Word(opNop, 0, 0), 0, 0, 0);
      addRow(regOpWord(opAdd, 4, 3, 3), 0, 0, 0);
      addRow(imm6Word(opSt, 4, 1, -2), 0, 0, 0);
      addRow(imm6Word(opLd, 5, 1, -2), 3, 0, 0);
      // branches taken and not taken
      addRow(imm8Word(opLdi, 1, 0), 0, 0, 0);
      addRow(imm8Word(opBeqz, 1, 5), 0, 0, 1);
      addRow(imm8Word(opBltz, 1, 3), 0, 0, 0);
      addRow(imm8Word(opLdi, 2, -4), 0, 0, 0);
      addRow(imm8Word(opBltz, 2, -6), 0, 0, 1);
      addRow(imm8Word(opBeqz, 2, 2), 2, 0, 0);
      // jal then jr on the link at distance 1 and 2
      addRow(jalWord('h40), 0, 0, 1);
      addRow(imm6Word(opJr, 0, 7, 0), 0, 0, 1);
      addRow(jalWord(-5), 0, 0, 1);
      addRow(imm8Word(opNop, 0, 0), 0, 0, 0);
      addRow(imm6Word(opJr, 0, 7, 0), 0, 0, 1);
      addRow(regOpWord(opAdd, 1, 7, 0), 4, 0, 0);
   endtask

   initial begin
      clk = 1'b0;
      forever #(clkPeriod / 2) clk = ~clk;
   end

   pipeCore dut (
      .clk           (clk),
      .arstN         (arstN),
      .instrValid    (instrValid),
      .instr         (instr),
      .pc            (pc),
      .wbValid       (wbValid),
      .wbReg         (wbReg),
      .wbData        (wbData),
      .redirectValid (redirectValid),
      .redirectPc    (redirectPc)
   );

   pipeChecker chk (
      .clk           (clk),
      .arstN         (arstN),
      .instrValid    (instrValid),
      .instr         (instr),
      .pc            (pc),
      .wbValid       (wbValid),
      .wbReg         (wbReg),
      .wbData        (wbData),
      .redirectValid (redirectValid),
      .redirectPc    (redirectPc),
      .passCount     (passCount),
      .failCount     (failCount),
      .retired       (retired)
   );

   // redirect count against the table's expectation
   always @(posedge clk) begin
      if (arstN === 1'b1 && redirectValid === 1'b1)
         redirSeen++;
   end

   initial begin
      logic [dataW-1:0] rndBits;
      int               timeoutNs;
      arstN      = 1'b1;
      instrValid = 1'b0;
      instr      = '0;
      pc         = '0;
      nRows      = 0;
      gapSum     = 0;
      expRedirs  = 0;
      redirSeen  = 0;
      topErrors  = 0;
      lfsr       = 32'h6084_31e1;
      buildTable();
      timeoutNs = (nRows + gapSum + 20) * clkPeriod;
      // watchdog
      fork
         begin
            #(timeoutNs);
            $display("timeout: %0d of %0d instructions retired after %0d ns",
                     retired, nRows, timeoutNs);
            $display("RESULT: FAIL");
            $finish;
         end
      join_none
      #1 arstN = 1'b0;
      repeat (4) @(posedge clk);
      @(negedge clk);
      arstN = 1'b1;
      for (int i = 0; i < nRows; i++) begin
         @(negedge clk);
         instr = tabInstr[i];
         if (tabRand[i]) begin
            takeRandBits(8, rndBits);
            instr[7:0] = rndBits[7:0];
         end
         pc         = tabPc[i];
         instrValid = 1'b1;
         repeat (tabGap[i]) begin
            @(negedge clk);
            instrValid = 1'b0;
         end
      end
      @(negedge clk);
      instrValid = 1'b0;
      wait (retired == nRows);
      // catch stray strobes after the last retire
      repeat (4) @(posedge clk);
      if (redirSeen != expRedirs) begin
         $display("CHECK FAILED redirectValid count: expected 0x%h got 0x%h",
                  expRedirs, redirSeen);
         topErrors++;
      end
      $display("passed %0d failed %0d", passCount, failCount + topErrors);
      if (failCount == 0 && topErrors == 0 && passCount == nRows) begin
         $display("RESULT: PASS");
      end else begin
         $display("RESULT: FAIL");
      end
      $finish;
   end

endmodule

// ==== all.f ====
src/cpuPkg.sv
src/stageIf.sv
src/regFile.sv
src/alu.sv
src/decodeStage.sv
src/forwardUnit.sv
src/executeStage.sv
src/memStage.sv
src/pipeCore.sv
tb/pipeChecker.sv
tb/tbPipeCore.sv

// ==== Bender.yml ====
package:
  name: pipeCore

sources:
  - src/cpuPkg.sv
  - src/stageIf.sv
  - src/regFile.sv
  - src/alu.sv
  - src/decodeStage.sv
  - src/forwardUnit.sv
  - src/executeStage.sv
  - src/memStage.sv
  - src/pipeCore.sv
  - target: test
    files:
      - tb/pipeChecker.sv
      - tb/tbPipeCore.sv
